// ==== tlx_cmd_pkg.sv ====
/* TLX command converter shared definitions
   field widths, command and fault structs and credit margins */
package tlx_cmd_pkg;

   // ------------------------------------------------------------------
   // field widths of the TLX command channel
   // ------------------------------------------------------------------
   localparam int unsigned opcode_w = 8;
   // effective address or object handle
   localparam int unsigned ea_w     = 68;
   localparam int unsigned afutag_w = 16;
   // data length code, 2'b10 means 128 bytes
   localparam int unsigned dl_w     = 2;
   localparam int unsigned pl_w     = 3;
   // one 64 byte data beat
   localparam int unsigned beat_w   = 512;

   // ------------------------------------------------------------------
   // payload types
   // ------------------------------------------------------------------
   // command as accepted from the accelerator and as issued to TLX
   typedef struct packed {
      logic [opcode_w-1:0] opcode;
      logic [ea_w-1:0]     ea_or_obj;
      logic [afutag_w-1:0] afutag;
      logic [dl_w-1:0]     dl;
      logic [pl_w-1:0]     pl;
   } tlx_cmd_t;

   // one write request, command plus up to two beats
   typedef struct packed {
      tlx_cmd_t          cmd;
      logic [beat_w-1:0] beat_even;
      logic [beat_w-1:0] beat_odd;
   } wr_req_t;

   // sticky fault bits, cleared only by reset
   typedef struct packed {
      logic wr_queue_ovfl;
      logic rd_queue_ovfl;
      logic cmd_credit_breach;
      logic data_credit_breach;
   } fault_t;

   // ------------------------------------------------------------------
   // constants
   // ------------------------------------------------------------------
   // 128 byte write, odd beat follows the even beat
   localparam logic [dl_w-1:0] dl_128b = 2'b10;
   // margins cover the decision to counter update pipeline
   localparam int unsigned cmd_credit_margin  = 3;
   localparam int unsigned data_credit_margin = 5;

endpackage

// ==== cmd_queue.sv ====
/* synchronous command queue, circular buffer with fill count
   half-full ready and sticky overflow on a push into a full queue */
module cmd_queue #(
   parameter type         payload_t    = logic [7:0],
   parameter int unsigned queue_addr_w = 5
) (
   input  logic     clk_tlx,
   input  logic     rst_n,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output payload_t head,
   output logic     not_empty,
   output logic     ready,
   output logic     ovfl
);

   localparam int unsigned depth = 2 ** queue_addr_w;

   // storage, no reset needed on the data path
   payload_t mem [depth];

   logic [queue_addr_w-1:0] wr_ptr;
   logic [queue_addr_w-1:0] rd_ptr;
   // one extra bit so a full queue is distinct from empty
   logic [queue_addr_w:0]   count;
   logic                    full;
   logic                    push_ok;
   logic                    pop_ok;

   assign full      = count[queue_addr_w];
   assign not_empty = |count;
   // ready drops once half the entries are taken
   assign ready     = ~|count[queue_addr_w:queue_addr_w-1];
   assign push_ok   = push && !full;
   assign pop_ok    = pop && not_empty;
   // oldest entry is always visible
   assign head      = mem[rd_ptr];

   always_ff @(posedge clk_tlx)
   begin
      if (push_ok)
         mem[wr_ptr] <= push_data;
   end

   // ------------------------------------------------------------------
   // pointers, fill count and overflow flag
   // ------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         ovfl   <= 1'b0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= rd_ptr + 1'b1;
         // simultaneous push and pop keeps the count
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // dropped push is remembered until reset
         if (push && full)
            ovfl <= 1'b1;
      end
   end

endmodule

// ==== credit_tracker.sv ====
/* TLX command and data credit counters
   registered low-credit flags and sticky credit breach flags */
module credit_tracker #(
   parameter int unsigned init_cmd_credit  = 8,
   parameter int unsigned init_data_credit = 16
) (
   input  logic clk_tlx,
   input  logic rst_n,
   input  logic cmd_credit,
   input  logic data_credit,
   input  logic cmd_valid,
   input  logic cdata_valid,
   output logic cmd_low,
   output logic data_low,
   output logic cmd_breach,
   output logic data_breach
);

   localparam int unsigned cmd_cnt_w  = $clog2(init_cmd_credit + 1);
   localparam int unsigned data_cnt_w = $clog2(init_data_credit + 1);

   logic [cmd_cnt_w-1:0]  cmd_cnt;
   logic [data_cnt_w-1:0] data_cnt;

   // ------------------------------------------------------------------
   // up/down counters, a return and a use together cancel out
   // ------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_cnt  <= cmd_cnt_w'(init_cmd_credit);
         data_cnt <= data_cnt_w'(init_data_credit);
      end
      else
      begin
         case ({cmd_credit, cmd_valid})
            2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
            2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
            default: cmd_cnt <= cmd_cnt;
         endcase
         // one data credit per 64 byte beat
         case ({data_credit, cdata_valid})
            2'b10:   data_cnt <= data_cnt + 1'b1;
            2'b01:   data_cnt <= data_cnt - 1'b1;
            default: data_cnt <= data_cnt;
         endcase
      end
   end

   // ------------------------------------------------------------------
   // low flags one cycle behind the count, breach flags sticky
   // ------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_low     <= 1'b0;
         data_low    <= 1'b0;
         cmd_breach  <= 1'b0;
         data_breach <= 1'b0;
      end
      else
      begin
         cmd_low  <= (cmd_cnt <= cmd_cnt_w'(tlx_cmd_pkg::cmd_credit_margin));
         data_low <= (data_cnt < data_cnt_w'(tlx_cmd_pkg::data_credit_margin));
         // command sent with no credit left
         if (cmd_valid && (cmd_cnt == '0))
            cmd_breach <= 1'b1;
         // beat sent with no data credit left
         if (cdata_valid && (data_cnt == '0))
            data_breach <= 1'b1;
      end
   end

endmodule

// ==== slot_scheduler.sv ====
/* issue slot scheduler, alternates write and read slots
   and sequences the odd data beat of a 128 byte write */
module slot_scheduler (
   input  logic                        clk_tlx,
   input  logic                        rst_n,
   input  logic                        wr_pending,
   input  logic                        rd_pending,
   input  logic                        cmd_low,
   input  logic                        data_low,
   input  logic [tlx_cmd_pkg::dl_w-1:0] wr_head_dl,
   output logic                        wr_pop,
   output logic                        rd_pop,
   output logic                        send_odd
);

   // slot owner, flips every cycle
   typedef enum logic {
      rd_slot = 1'b0,
      wr_slot = 1'b1
   } phase_t;

   phase_t phase;
   logic   odd_pending;

   // ------------------------------------------------------------------
   // pop decisions
   // ------------------------------------------------------------------
   // writes need both command and data credit headroom
   assign wr_pop = (phase == wr_slot) && wr_pending && !cmd_low && !data_low;
   // reads carry no data, only command credit matters
   assign rd_pop = (phase == rd_slot) && rd_pending && !cmd_low;

   // odd beat goes out one cycle after the even beat
   assign send_odd = odd_pending;

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         phase       <= rd_slot;
         odd_pending <= 1'b0;
      end
      else
      begin
         phase <= (phase == wr_slot) ? rd_slot : wr_slot;
         // single cycle state, write pops never land back to back
         odd_pending <= wr_pop && (wr_head_dl == tlx_cmd_pkg::dl_128b);
      end
   end

endmodule

// ==== cmd_issue_stage.sv ====
/* TLX issue register, selects the popped queue head
   drives the command and command-data channels */
module cmd_issue_stage (
   input  logic                          clk_tlx,
   input  logic                          rst_n,
   input  tlx_cmd_pkg::wr_req_t          wr_head,
   input  tlx_cmd_pkg::tlx_cmd_t         rd_head,
   input  logic                          wr_pop,
   input  logic                          rd_pop,
   input  logic                          send_odd,
   output logic                          cmd_valid,
   output tlx_cmd_pkg::tlx_cmd_t         cmd,
   output logic                          cdata_valid,
   output logic [tlx_cmd_pkg::beat_w-1:0] cdata
);

   // odd half of the last popped write
   logic [tlx_cmd_pkg::beat_w-1:0] odd_beat;

   // ------------------------------------------------------------------
   // valid strobes
   // ------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cmd_valid   <= 1'b0;
         cdata_valid <= 1'b0;
      end
      else
      begin
         // at most one pop per cycle from the scheduler
         cmd_valid   <= wr_pop || rd_pop;
         // even beat with the write command, odd beat one cycle later
         cdata_valid <= wr_pop || send_odd;
      end
   end

   // ------------------------------------------------------------------
   // payload registers
   // ------------------------------------------------------------------
   always_ff @(posedge clk_tlx)
   begin
      if (wr_pop)
      begin
         cmd      <= wr_head.cmd;
         cdata    <= wr_head.beat_even;
         odd_beat <= wr_head.beat_odd;
      end
      else
      begin
         if (rd_pop)
            cmd <= rd_head;
         // odd beat may share a cycle with a read command
         if (send_odd)
            cdata <= odd_beat;
      end
   end

endmodule

// ==== tlx_cmd_converter.sv ====
/* TLX command converter top level
   write and read queues, slot scheduler, credit tracking, issue stage */
module tlx_cmd_converter #(
   parameter int unsigned queue_addr_w     = 5,
   parameter int unsigned init_cmd_credit  = 8,
   parameter int unsigned init_data_credit = 16
) (
   input  logic                          clk_tlx,
   input  logic                          rst_n,
   // accelerator write channel
   input  logic                          wr_valid,
   input  tlx_cmd_pkg::wr_req_t          wr_req,
   output logic                          wr_ready,
   // accelerator read channel
   input  logic                          rd_valid,
   input  tlx_cmd_pkg::tlx_cmd_t         rd_cmd,
   output logic                          rd_ready,
   // TLX command and command-data
   output logic                          cmd_valid,
   output tlx_cmd_pkg::tlx_cmd_t         cmd,
   output logic                          cdata_valid,
   output logic [tlx_cmd_pkg::beat_w-1:0] cdata,
   // TLX credit returns
   input  logic                          cmd_credit,
   input  logic                          data_credit,
   output tlx_cmd_pkg::fault_t           fault
);

   tlx_cmd_pkg::wr_req_t  wr_head;
   tlx_cmd_pkg::tlx_cmd_t rd_head;
   logic                  wr_not_empty;
   logic                  rd_not_empty;
   logic                  wr_pop;
   logic                  rd_pop;
   logic                  wr_ovfl;
   logic                  rd_ovfl;
   logic                  cmd_low;
   logic                  data_low;
   logic                  cmd_breach;
   logic                  data_breach;
   logic                  send_odd;

   // ------------------------------------------------------------------
   // accelerator side queues
   // ------------------------------------------------------------------
   cmd_queue #(
      .payload_t    (tlx_cmd_pkg::wr_req_t),
      .queue_addr_w (queue_addr_w)
   ) u_wr_queue (
      .clk_tlx   (clk_tlx),
      .rst_n     (rst_n),
      .push      (wr_valid),
      .push_data (wr_req),
      .pop       (wr_pop),
      .head      (wr_head),
      .not_empty (wr_not_empty),
      .ready     (wr_ready),
      .ovfl      (wr_ovfl)
   );

   cmd_queue #(
      .payload_t    (tlx_cmd_pkg::tlx_cmd_t),
      .queue_addr_w (queue_addr_w)
   ) u_rd_queue (
      .clk_tlx   (clk_tlx),
      .rst_n     (rst_n),
      .push      (rd_valid),
      .push_data (rd_cmd),
      .pop       (rd_pop),
      .head      (rd_head),
      .not_empty (rd_not_empty),
      .ready     (rd_ready),
      .ovfl      (rd_ovfl)
   );

   // ------------------------------------------------------------------
   // scheduling and credits
   // ------------------------------------------------------------------
   slot_scheduler u_slot_scheduler (
      .clk_tlx    (clk_tlx),
      .rst_n      (rst_n),
      .wr_pending (wr_not_empty),
      .rd_pending (rd_not_empty),
      .cmd_low    (cmd_low),
      .data_low   (data_low),
      .wr_head_dl (wr_head.cmd.dl),
      .wr_pop     (wr_pop),
      .rd_pop     (rd_pop),
      .send_odd   (send_odd)
   );

   credit_tracker #(
      .init_cmd_credit  (init_cmd_credit),
      .init_data_credit (init_data_credit)
   ) u_credit_tracker (
      .clk_tlx     (clk_tlx),
      .rst_n       (rst_n),
      .cmd_credit  (cmd_credit),
      .data_credit (data_credit),
      .cmd_valid   (cmd_valid),
      .cdata_valid (cdata_valid),
      .cmd_low     (cmd_low),
      .data_low    (data_low),
      .cmd_breach  (cmd_breach),
      .data_breach (data_breach)
   );

   // TLX output register
   cmd_issue_stage u_cmd_issue_stage (
      .clk_tlx     (clk_tlx),
      .rst_n       (rst_n),
      .wr_head     (wr_head),
      .rd_head     (rd_head),
      .wr_pop      (wr_pop),
      .rd_pop      (rd_pop),
      .send_odd    (send_odd),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .cdata_valid (cdata_valid),
      .cdata       (cdata)
   );

   // sticky fault bits gathered for the host
   assign fault.wr_queue_ovfl      = wr_ovfl;
   assign fault.rd_queue_ovfl      = rd_ovfl;
   assign fault.cmd_credit_breach  = cmd_breach;
   assign fault.data_credit_breach = data_breach;

endmodule

// ==== tlx_cmd_converter_chk.sv ====
/* concurrent checks on the TLX side of the command converter */
module tlx_cmd_converter_chk (
   input logic                 clk_tlx,
   input logic                 rst_n,
   input logic                 cmd_valid,
   input logic                 cdata_valid,
   input logic                 cmd_breach,
   input logic                 data_breach,
   input logic                 wr_pop,
   input tlx_cmd_pkg::wr_req_t wr_head
);
   timeunit 1ns;
   timeprecision 1ps;

   // issue register is cleared by reset
   cmd_quiet_in_reset: assert property (@(posedge clk_tlx) !rst_n |-> !cmd_valid)
      else $error("command issued while reset is asserted");

   // margins leave a credit for every command and beat in flight
   cmd_credit_kept: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      cmd_valid |=> !cmd_breach)
      else $error("command issued with no command credit left");

   data_credit_kept: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      cdata_valid |=> !data_breach)
      else $error("data beat issued with no data credit left");

   // 128 byte write, even beat with the command then the odd beat
   odd_beat_follows: assert property (@(posedge clk_tlx) disable iff (!rst_n)
      wr_pop && (wr_head.cmd.dl == tlx_cmd_pkg::dl_128b)
      |=> cmd_valid && cdata_valid ##1 cdata_valid)
      else $error("odd data beat did not follow a 128 byte write");

endmodule

bind tlx_cmd_converter tlx_cmd_converter_chk i_tlx_cmd_converter_chk (
   .clk_tlx     (clk_tlx),
   .rst_n       (rst_n),
   .cmd_valid   (cmd_valid),
   .cdata_valid (cdata_valid),
   .cmd_breach  (cmd_breach),
   .data_breach (data_breach),
   .wr_pop      (wr_pop),
   .wr_head     (wr_head)
);

// ==== tb_tlx_cmd_converter.sv ====
/* testbench for the TLX command converter
   random requests against reference queues, credit return and fault checks */
module tb_tlx_cmd_converter;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned queue_addr_w     = 5;
   localparam int unsigned init_cmd_credit  = 8;
   localparam int unsigned init_data_credit = 16;
   localparam int unsigned beat_w           = tlx_cmd_pkg::beat_w;
   // longest any single wait may run, in cycles
   localparam int          wait_limit       = 2000;

   logic                  clk_tlx;
   logic                  rst_n;
   logic                  wr_valid;
   tlx_cmd_pkg::wr_req_t  wr_req;
   logic                  wr_ready;
   logic                  rd_valid;
   tlx_cmd_pkg::tlx_cmd_t rd_cmd;
   logic                  rd_ready;
   logic                  cmd_valid;
   tlx_cmd_pkg::tlx_cmd_t cmd;
   logic                  cdata_valid;
   logic [beat_w-1:0]     cdata;
   logic                  cmd_credit;
   logic                  data_credit;
   tlx_cmd_pkg::fault_t   fault;

   int seed = 32'h73b5;
   // expected TLX traffic, one queue per channel plus the beat stream
   tlx_cmd_pkg::tlx_cmd_t exp_wr_cmd[$];
   tlx_cmd_pkg::tlx_cmd_t exp_rd_cmd[$];
   logic [beat_w-1:0]     exp_beat[$];
   bit odd_due;
   bit credit_on;
   // data credits held back while command credits still return
   bit hold_data;
   bit saw_wr_busy;
   int owed_cmd;
   int owed_data;
   int cmds_seen;
   int beats_seen;

   tlx_cmd_converter #(
      .queue_addr_w     (queue_addr_w),
      .init_cmd_credit  (init_cmd_credit),
      .init_data_credit (init_data_credit)
   ) i_tlx_cmd_converter (.*);

   initial
   begin
      clk_tlx = 1'b0;
      forever #2 clk_tlx = ~clk_tlx;
   end

   // ------------------------------------------------------------------
   // reporting and compare tasks
   // ------------------------------------------------------------------
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_cmd(input string name, input tlx_cmd_pkg::tlx_cmd_t got,
                            input tlx_cmd_pkg::tlx_cmd_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         abort_run("command differs from the reference model");
      end
   endtask

   task automatic check_beat(input string name, input logic [beat_w-1:0] got,
                             input logic [beat_w-1:0] exp);
      if (got !== exp)
      begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         abort_run("data beat differs from the reference model");
      end
   endtask

   task automatic check_fault(input string name, input tlx_cmd_pkg::fault_t got,
                              input tlx_cmd_pkg::fault_t exp);
      if (got !== exp)
      begin
         $display("FAILED %s got %h expected %h", name, got, exp);
         abort_run("fault flags differ from the expected state");
      end
   endtask

   // ------------------------------------------------------------------
   // reference model and random requests
   // ------------------------------------------------------------------
   function automatic void expect_request(input bit is_wr, input tlx_cmd_pkg::wr_req_t req,
                                          input tlx_cmd_pkg::tlx_cmd_t rc);
      if (is_wr)
      begin
         exp_wr_cmd.push_back(req.cmd);
         exp_beat.push_back(req.beat_even);
         // only a 128 byte write carries the odd beat
         if (req.cmd.dl == tlx_cmd_pkg::dl_128b)
            exp_beat.push_back(req.beat_odd);
      end
      else
         exp_rd_cmd.push_back(rc);
   endfunction

   function automatic tlx_cmd_pkg::tlx_cmd_t rand_cmd();
      tlx_cmd_pkg::tlx_cmd_t c;
      c.opcode    = 8'($random(seed));
      c.ea_or_obj = {4'($random(seed)), 32'($random(seed)), 32'($random(seed))};
      c.afutag    = 16'($random(seed));
      // about half use the 128 byte code
      c.dl        = ($random(seed) & 1) ? tlx_cmd_pkg::dl_128b : 2'($random(seed));
      c.pl        = 3'($random(seed));
      return c;
   endfunction

   function automatic logic [beat_w-1:0] rand_beat();
      logic [beat_w-1:0] b;
      for (int i = 0; i < beat_w / 32; i++)
         b[i*32 +: 32] = $random(seed);
      return b;
   endfunction

   // ------------------------------------------------------------------
   // stimulus tasks, called 1 ns after a rising edge
   // ------------------------------------------------------------------
   task automatic apply_reset();
      rst_n = 1'b0;
      @(negedge clk_tlx);
      // bookkeeping restarts with the DUT
      exp_wr_cmd.delete();
      exp_rd_cmd.delete();
      exp_beat.delete();
      odd_due   = 1'b0;
      owed_cmd  = 0;
      owed_data = 0;
      repeat (8) @(posedge clk_tlx);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic check_idle();
      if (cmd_valid !== 1'b0 || cdata_valid !== 1'b0)
         abort_run("TLX outputs are active right after reset");
      if (wr_ready !== 1'b1 || rd_ready !== 1'b1)
         abort_run("queue ready is low right after reset");
      check_fault("fault", fault, '0);
   endtask

   // random gaps, ready honored unless overflow is the goal
   task automatic send_traffic(input int n_wr, input int n_rd, input bit use_ready);
      int sent_wr;
      int sent_rd;
      int cycles;
      bit do_wr;
      bit do_rd;
      tlx_cmd_pkg::wr_req_t  req;
      tlx_cmd_pkg::tlx_cmd_t rc;
      sent_wr = 0;
      sent_rd = 0;
      cycles  = 0;
      while (sent_wr < n_wr || sent_rd < n_rd)
      begin
         if (cycles == wait_limit)
            abort_run("timeout while pushing requests into the DUT");
         if (!wr_ready)
            saw_wr_busy = 1'b1;
         req.cmd       = rand_cmd();
         req.beat_even = rand_beat();
         req.beat_odd  = rand_beat();
         rc            = rand_cmd();
         do_wr = (sent_wr < n_wr) && (($random(seed) & 3) != 0) && (wr_ready || !use_ready);
         do_rd = (sent_rd < n_rd) && (($random(seed) & 3) != 0) && (rd_ready || !use_ready);
         wr_valid = do_wr;
         wr_req   = req;
         rd_valid = do_rd;
         rd_cmd   = rc;
         if (do_wr)
            expect_request(1'b1, req, rc);
         if (do_rd)
            expect_request(1'b0, req, rc);
         @(posedge clk_tlx);
         #1;
         sent_wr += int'(do_wr);
         sent_rd += int'(do_rd);
         cycles++;
      end
      wr_valid = 1'b0;
      rd_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_wr_cmd.size() != 0 || exp_rd_cmd.size() != 0 || exp_beat.size() != 0
             || owed_cmd != 0 || owed_data != 0)
      begin
         if (cycles == wait_limit)
            abort_run("timeout waiting for queued commands and credits to drain");
         @(posedge clk_tlx);
         #1;
         cycles++;
      end
      // counters and low flags settle
      repeat (4) @(posedge clk_tlx);
      #1;
   endtask

   // ------------------------------------------------------------------
   // TLX side, credit return and output compare
   // ------------------------------------------------------------------
   always @(posedge clk_tlx)
   begin : return_credits
      #1;
      cmd_credit  = credit_on && rst_n && (owed_cmd > 0);
      data_credit = credit_on && !hold_data && rst_n && (owed_data > 0);
      if (cmd_credit)
         owed_cmd--;
      if (data_credit)
         owed_data--;
   end

   always @(negedge clk_tlx)
   begin : compare_outputs
      tlx_cmd_pkg::tlx_cmd_t exp_c;
      bit odd_now;
      bit wr_cmd;
      if (rst_n)
      begin
         odd_now = odd_due;
         odd_due = 1'b0;
         // a write command always comes with its even beat
         wr_cmd  = cmd_valid && cdata_valid && !odd_now;
         if (cmd_valid)
            owed_cmd++;
         if (cdata_valid)
         begin
            owed_data++;
            beats_seen++;
            if (!odd_now && !cmd_valid)
               abort_run("data beat issued without a write command");
            if (exp_beat.size() == 0)
               abort_run("data beat issued but none was expected");
            check_beat("cdata", cdata, exp_beat.pop_front());
         end
         else if (odd_now)
            abort_run("odd data beat missing after a 128 byte write");
         if (wr_cmd)
         begin
            if (exp_wr_cmd.size() == 0)
               abort_run("write command issued but no write was pending");
            exp_c   = exp_wr_cmd.pop_front();
            check_cmd("cmd", cmd, exp_c);
            odd_due = (exp_c.dl == tlx_cmd_pkg::dl_128b);
         end
         else if (cmd_valid)
         begin
            if (exp_rd_cmd.size() == 0)
               abort_run("read command issued but no read was pending");
            check_cmd("cmd", cmd, exp_rd_cmd.pop_front());
         end
         if (cmd_valid)
            cmds_seen++;
      end
   end

   // ------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------
   initial
   begin : main
      int base_cmds;
      int base_beats;
      int stop_cmds;
      int stop_beats;
      rst_n       = 1'b0;
      wr_valid    = 1'b0;
      wr_req      = '0;
      rd_valid    = 1'b0;
      rd_cmd      = '0;
      cmd_credit  = 1'b0;
      data_credit = 1'b0;
      credit_on   = 1'b1;
      hold_data   = 1'b0;
      saw_wr_busy = 1'b0;
      cmds_seen   = 0;
      beats_seen  = 0;
      apply_reset();
      check_idle();
      // writes only, then reads only, then both
      send_traffic(24, 0, 1'b1);
      wait_drain();
      send_traffic(0, 20, 1'b1);
      wait_drain();
      send_traffic(40, 40, 1'b1);
      wait_drain();
      // starvation, output must stop short of the credit counts
      credit_on  = 1'b0;
      base_cmds  = cmds_seen;
      send_traffic(10, 6, 1'b1);
      repeat (40) @(posedge clk_tlx);
      stop_cmds = cmds_seen;
      repeat (20) @(posedge clk_tlx);
      #1;
      if (cmds_seen == base_cmds)
         abort_run("no command issued before the credits ran low");
      if (cmds_seen - base_cmds >= int'(init_cmd_credit))
         abort_run("more commands issued than command credits");
      if (cmds_seen != stop_cmds)
         abort_run("commands kept going out without credit returns");
      check_fault("fault", fault, '0);
      credit_on = 1'b1;
      wait_drain();
      // data credits alone run out, command credits keep coming back
      hold_data  = 1'b1;
      base_beats = beats_seen;
      send_traffic(14, 0, 1'b1);
      repeat (40) @(posedge clk_tlx);
      stop_beats = beats_seen;
      repeat (20) @(posedge clk_tlx);
      #1;
      if (exp_wr_cmd.size() == 0)
         abort_run("all writes issued, the data credits never ran low");
      if (beats_seen - base_beats >= int'(init_data_credit))
         abort_run("more data beats issued than data credits");
      if (beats_seen != stop_beats)
         abort_run("data beats kept going out without data credit returns");
      check_fault("fault", fault, '0);
      hold_data = 1'b0;
      wait_drain();
      // overflow of the write queue with credits held back
      credit_on   = 1'b0;
      saw_wr_busy = 1'b0;
      send_traffic(48, 0, 1'b0);
      repeat (4) @(posedge clk_tlx);
      #1;
      if (!saw_wr_busy)
         abort_run("wr_ready never fell while the write queue filled");
      check_fault("fault", fault,
                  tlx_cmd_pkg::fault_t'{wr_queue_ovfl: 1'b1, default: 1'b0});
      credit_on = 1'b1;
      apply_reset();
      check_idle();
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

// ==== tb.f ====
tlx_cmd_pkg.sv
cmd_queue.sv
credit_tracker.sv
slot_scheduler.sv
cmd_issue_stage.sv
tlx_cmd_converter.sv
tlx_cmd_converter_chk.sv
tb_tlx_cmd_converter.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the TLX command converter testbench with Verilator
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_tlx_cmd_converter -f tb.f -o tb_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
   cat "$build_log"
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

# the testbench prints its failure line before it stops
if grep -q "Simulation failed" "$sim_log"; then
   exit 1
fi
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi
exit 0
